// ==== hw/s16_char_pkg.sv ====
// Character layer package with frame geometry, CPU address map and shared vector types
package s16_char_pkg;

    // Tile and frame geometry
    localparam int TILE_PX   = 8;
    localparam int FRAME_W   = 32;
    localparam int FRAME_H   = 16;
    localparam int MAP_COLS  = FRAME_W / TILE_PX;
    localparam int MAP_ROWS  = FRAME_H / TILE_PX;
    localparam int MAP_WORDS = MAP_COLS * MAP_ROWS;
    localparam int PAL_WORDS = 128;

    // Graphics ROM slots granted after reset
    localparam int FETCH_CREDITS = 4;

    // CPU word addresses
    typedef logic [8:0]  cpu_addr_t;
    typedef logic [15:0] cpu_data_t;

    localparam cpu_addr_t ADDR_MAP_BASE = 9'h000;
    localparam cpu_addr_t ADDR_PAL_BASE = 9'h080;
    localparam cpu_addr_t ADDR_CTRL     = 9'h100;

    // Control register bits
    localparam int CTRL_GO_BIT   = 0;
    localparam int CTRL_FLIP_BIT = 1;
    localparam int CTRL_EN_BIT   = 2;

    // Tile code in 7:0, palette bank in 10:8
    typedef logic [15:0] map_entry_t;
    // Code times eight plus line in tile
    typedef logic [10:0] rom_addr_t;
    // Eight 4bpp pixels, leftmost in the top nibble
    typedef logic [31:0] rom_data_t;
    typedef logic [2:0]  pal_bank_t;
    typedef logic [6:0]  pal_idx_t;
    typedef logic [4:0]  chan_t;
    typedef logic [2:0]  credit_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RUN,
        FETCH_DRAIN
    } fetch_state_t;

endpackage

// ==== hw/s16_bus_decode.sv ====
// CPU write decoder steering tile map and palette writes and holding the control register
`timescale 1ns/1ns

module s16_bus_decode (
    input  logic                     clk,
    input  logic                     arst_n,
    input  s16_char_pkg::cpu_addr_t  cpu_addr,
    input  s16_char_pkg::cpu_data_t  cpu_dout,
    input  logic                     cpu_we,
    output logic                     map_we,
    output logic [2:0]               map_addr,
    output s16_char_pkg::map_entry_t map_data,
    output logic                     pal_we,
    output s16_char_pkg::pal_idx_t   pal_addr,
    output logic [14:0]              pal_data,
    output logic                     render_go,
    output logic                     flip,
    output logic                     video_en
);
    import s16_char_pkg::*;

    cpu_addr_t map_off;
    cpu_addr_t pal_off;
    logic      map_hit;
    logic      pal_hit;
    logic      ctrl_hit;
    logic      ctrl_we_q;
    logic      ctrl_flip_q;
    logic      ctrl_en_q;

    // Offsets wrap below the base, so one compare covers the range
    assign map_off  = cpu_addr - ADDR_MAP_BASE;
    assign pal_off  = cpu_addr - ADDR_PAL_BASE;
    assign map_hit  = map_off < cpu_addr_t'(MAP_WORDS);
    assign pal_hit  = pal_off < cpu_addr_t'(PAL_WORDS);
    assign ctrl_hit = cpu_addr == ADDR_CTRL;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            map_we    <= 1'b0;
            pal_we    <= 1'b0;
            ctrl_we_q <= 1'b0;
            render_go <= 1'b0;
            flip      <= 1'b0;
            video_en  <= 1'b0;
        end else begin
            map_we    <= cpu_we && map_hit;
            pal_we    <= cpu_we && pal_hit;
            ctrl_we_q <= cpu_we && ctrl_hit;
            // Go is a strobe, not a stored bit
            render_go <= cpu_we && ctrl_hit && cpu_dout[CTRL_GO_BIT];
            if (ctrl_we_q) begin
                flip     <= ctrl_flip_q;
                video_en <= ctrl_en_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        map_addr    <= map_off[2:0];
        map_data    <= map_entry_t'(cpu_dout);
        pal_addr    <= pal_idx_t'(pal_off);
        pal_data    <= cpu_dout[14:0];
        ctrl_flip_q <= cpu_dout[CTRL_FLIP_BIT];
        ctrl_en_q   <= cpu_dout[CTRL_EN_BIT];
    end

endmodule

// ==== hw/s16_char_fetch.sv ====
// Character tile fetch with frame walker, credit-limited ROM requests and row return queue
`timescale 1ns/1ns

module s16_char_fetch (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     map_we,
    input  logic [2:0]               map_addr,
    input  s16_char_pkg::map_entry_t map_data,
    input  logic                     render_go,
    input  logic                     flip,
    output logic                     rom_req,
    output s16_char_pkg::rom_addr_t  rom_addr,
    input  logic                     rom_credit,
    input  logic                     rom_valid,
    input  s16_char_pkg::rom_data_t  rom_data,
    output logic                     row_valid,
    input  logic                     row_ready,
    output s16_char_pkg::rom_data_t  row_data,
    output s16_char_pkg::pal_bank_t  row_bank,
    output logic                     row_last
);
    import s16_char_pkg::*;

    map_entry_t   map_mem [MAP_WORDS];
    fetch_state_t state;
    logic [3:0]   line_q;
    logic [1:0]   col_q;
    logic [1:0]   tile_col;
    map_entry_t   cur_entry;
    logic         last_req;
    credit_t      credit_q;
    credit_t      outstanding;
    logic         row_fire;
    rom_data_t    rom_rev;

    // Pointers carry one extra wrap bit over the queue index
    credit_t iss_ptr;
    credit_t ret_ptr;
    credit_t rd_ptr;

    // Side queue written at issue, row data written at return
    pal_bank_t side_bank [FETCH_CREDITS];
    logic      side_flip [FETCH_CREDITS];
    logic      side_last [FETCH_CREDITS];
    rom_data_t row_mem   [FETCH_CREDITS];

    always_ff @(posedge clk) begin
        if (map_we) begin
            map_mem[map_addr] <= map_data;
        end
    end

    assign tile_col  = flip ? 2'(MAP_COLS - 1) - col_q : col_q;
    // Upper line bit selects the tile row
    assign cur_entry = map_mem[{line_q[3], tile_col}];
    assign last_req  = (line_q == 4'(FRAME_H - 1)) && (col_q == 2'(MAP_COLS - 1));

    // Requests issued but not yet handed to the colour block
    assign outstanding = iss_ptr - rd_ptr;
    assign rom_req  = (state == FETCH_RUN) && (credit_q != '0)
                   && (outstanding < credit_t'(FETCH_CREDITS));
    assign rom_addr = {cur_entry[7:0], line_q[2:0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= FETCH_IDLE;
            line_q <= '0;
            col_q  <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (render_go) begin
                        state  <= FETCH_RUN;
                        line_q <= '0;
                        col_q  <= '0;
                    end
                end
                FETCH_RUN: begin
                    if (rom_req) begin
                        col_q <= col_q + 2'd1;
                        if (col_q == 2'(MAP_COLS - 1)) begin
                            line_q <= line_q + 4'd1;
                        end
                        if (last_req) begin
                            state <= FETCH_DRAIN;
                        end
                    end
                end
                FETCH_DRAIN: begin
                    // Wait for every row to leave before accepting go again
                    if (outstanding == '0) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_q <= credit_t'(FETCH_CREDITS);
            iss_ptr  <= '0;
            ret_ptr  <= '0;
            rd_ptr   <= '0;
        end else begin
            case ({rom_req, rom_credit})
                2'b10:   credit_q <= credit_q - 3'd1;
                2'b01:   credit_q <= credit_q + 3'd1;
                default: credit_q <= credit_q;
            endcase
            if (rom_req) begin
                iss_ptr <= iss_ptr + 3'd1;
            end
            if (rom_valid) begin
                ret_ptr <= ret_ptr + 3'd1;
            end
            if (row_fire) begin
                rd_ptr <= rd_ptr + 3'd1;
            end
        end
    end

    // Mirror the eight pixels of a flipped row
    always_comb begin
        for (int i = 0; i < TILE_PX; i++) begin
            rom_rev[4*i +: 4] = rom_data[4*(TILE_PX-1-i) +: 4];
        end
    end

    always_ff @(posedge clk) begin
        if (rom_req) begin
            side_bank[iss_ptr[1:0]] <= cur_entry[10:8];
            side_flip[iss_ptr[1:0]] <= flip;
            side_last[iss_ptr[1:0]] <= last_req;
        end
        if (rom_valid) begin
            row_mem[ret_ptr[1:0]] <= side_flip[ret_ptr[1:0]] ? rom_rev : rom_data;
        end
    end

    assign row_valid = ret_ptr != rd_ptr;
    assign row_fire  = row_valid && row_ready;
    assign row_data  = row_mem[rd_ptr[1:0]];
    assign row_bank  = side_bank[rd_ptr[1:0]];
    assign row_last  = side_last[rd_ptr[1:0]];

endmodule

// ==== hw/s16_char_colmix.sv ====
// Character colour block turning tile rows into palette-mapped 15-bit RGB pixels
`timescale 1ns/1ns

module s16_char_colmix (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    pal_we,
    input  s16_char_pkg::pal_idx_t  pal_addr,
    input  logic [14:0]             pal_data,
    input  logic                    video_en,
    input  logic                    row_valid,
    output logic                    row_ready,
    input  s16_char_pkg::rom_data_t row_data,
    input  s16_char_pkg::pal_bank_t row_bank,
    input  logic                    row_last,
    output logic                    pix_valid,
    input  logic                    pix_ready,
    output s16_char_pkg::chan_t     red,
    output s16_char_pkg::chan_t     green,
    output s16_char_pkg::chan_t     blue,
    output logic                    pix_last
);
    import s16_char_pkg::*;

    logic [14:0] pal_mem [PAL_WORDS];
    rom_data_t   shift_q;
    pal_bank_t   bank_q;
    logic        last_q;
    logic [2:0]  left_q;
    logic        advance;
    logic        take_row;
    pal_idx_t    rd_idx;
    logic [14:0] colour;

    // Output register moves when empty or when its pixel is taken
    assign advance   = !pix_valid || pix_ready;
    assign row_ready = advance && (left_q == '0);
    assign take_row  = row_valid && row_ready;

    // First pixel of a new row goes straight to the lookup
    assign rd_idx = take_row ? {row_bank, row_data[31:28]} : {bank_q, shift_q[31:28]};
    assign colour = video_en ? pal_mem[rd_idx] : 15'd0;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[pal_addr] <= pal_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_valid <= 1'b0;
            pix_last  <= 1'b0;
            left_q    <= '0;
        end else if (advance) begin
            if (left_q != '0) begin
                pix_valid <= 1'b1;
                pix_last  <= last_q && (left_q == 3'd1);
                left_q    <= left_q - 3'd1;
            end else if (row_valid) begin
                pix_valid <= 1'b1;
                pix_last  <= 1'b0;
                left_q    <= 3'(TILE_PX - 1);
            end else begin
                pix_valid <= 1'b0;
                pix_last  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            red   <= colour[14:10];
            green <= colour[9:5];
            blue  <= colour[4:0];
            if (take_row) begin
                shift_q <= row_data << 4;
                bank_q  <= row_bank;
                last_q  <= row_last;
            end else if (left_q != '0) begin
                shift_q <= shift_q << 4;
            end
        end
    end

endmodule

// ==== hw/s16_char_game.sv ====
// Character layer top level joining CPU decode, tile fetch and colour output
`timescale 1ns/1ns

module s16_char_game (
    input  logic                    clk,
    input  logic                    arst_n,
    // CPU bus
    input  s16_char_pkg::cpu_addr_t cpu_addr,
    input  s16_char_pkg::cpu_data_t cpu_dout,
    input  logic                    cpu_we,
    // Graphics ROM with credit return
    output logic                    rom_req,
    output s16_char_pkg::rom_addr_t rom_addr,
    input  logic                    rom_credit,
    input  logic                    rom_valid,
    input  s16_char_pkg::rom_data_t rom_data,
    // Pixel stream
    output logic                    pix_valid,
    input  logic                    pix_ready,
    output s16_char_pkg::chan_t     red,
    output s16_char_pkg::chan_t     green,
    output s16_char_pkg::chan_t     blue,
    output logic                    pix_last
);
    import s16_char_pkg::*;

    logic        map_we;
    logic [2:0]  map_addr;
    map_entry_t  map_data;
    logic        pal_we;
    pal_idx_t    pal_addr;
    logic [14:0] pal_data;
    logic        render_go, flip, video_en;
    logic        row_valid, row_ready, row_last;
    rom_data_t   row_data;
    pal_bank_t   row_bank;

    s16_bus_decode u_decode (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .cpu_we     ( cpu_we     ),
        .map_we     ( map_we     ),
        .map_addr   ( map_addr   ),
        .map_data   ( map_data   ),
        .pal_we     ( pal_we     ),
        .pal_addr   ( pal_addr   ),
        .pal_data   ( pal_data   ),
        .render_go  ( render_go  ),
        .flip       ( flip       ),
        .video_en   ( video_en   )
    );

    s16_char_fetch u_fetch (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .map_we     ( map_we     ),
        .map_addr   ( map_addr   ),
        .map_data   ( map_data   ),
        .render_go  ( render_go  ),
        .flip       ( flip       ),
        .rom_req    ( rom_req    ),
        .rom_addr   ( rom_addr   ),
        .rom_credit ( rom_credit ),
        .rom_valid  ( rom_valid  ),
        .rom_data   ( rom_data   ),
        .row_valid  ( row_valid  ),
        .row_ready  ( row_ready  ),
        .row_data   ( row_data   ),
        .row_bank   ( row_bank   ),
        .row_last   ( row_last   )
    );

    s16_char_colmix u_colmix (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .pal_we     ( pal_we     ),
        .pal_addr   ( pal_addr   ),
        .pal_data   ( pal_data   ),
        .video_en   ( video_en   ),
        .row_valid  ( row_valid  ),
        .row_ready  ( row_ready  ),
        .row_data   ( row_data   ),
        .row_bank   ( row_bank   ),
        .row_last   ( row_last   ),
        .pix_valid  ( pix_valid  ),
        .pix_ready  ( pix_ready  ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .pix_last   ( pix_last   )
    );

endmodule

// ==== tb/s16_char_asserts.sv ====
// Credit link and reset checks on the character fetch block
`timescale 1ns/1ns

module s16_char_asserts (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    rom_req,
    input logic                    rom_credit,
    input s16_char_pkg::credit_t   credit_q,
    input logic                    row_valid,
    input logic                    row_ready,
    input s16_char_pkg::rom_data_t row_data
);
    import s16_char_pkg::*;

    credit_t link_credits;

    // Slots seen on the link itself, granted at reset and returned by the ROM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            link_credits <= credit_t'(FETCH_CREDITS);
        end else begin
            link_credits <= link_credits + credit_t'(rom_credit) - credit_t'(rom_req);
        end
    end

    // A request spends a slot the ROM has actually granted
    req_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        rom_req |-> link_credits != '0)
        else $error("rom_req raised with zero credits");

    credit_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        credit_q <= credit_t'(FETCH_CREDITS))
        else $error("credit counter above the granted slots");

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !rom_req && !row_valid)
        else $error("request or row valid during reset");

    // Row held until the colour block takes it
    row_held: assert property (@(posedge clk) disable iff (!arst_n)
        row_valid && !row_ready |=> row_valid && $stable(row_data))
        else $error("row data changed while stalled");

endmodule

bind s16_char_fetch s16_char_asserts u_asserts (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .rom_req    ( rom_req    ),
    .rom_credit ( rom_credit ),
    .credit_q   ( credit_q   ),
    .row_valid  ( row_valid  ),
    .row_ready  ( row_ready  ),
    .row_data   ( row_data   )
);

// ==== tb/tb_s16_char_game.sv ====
// Testbench for the character layer with ROM credit model, reference frame and data file
`timescale 1ns/1ns

module tb_s16_char_game;
    import s16_char_pkg::*;

    localparam int FRAME_PIXELS  = FRAME_W * FRAME_H;
    localparam int FRAME_REQS    = MAP_COLS * FRAME_H;
    localparam int FRAME_TIMEOUT = 20000;
    localparam int QUIET_CYCLES  = 64;
    localparam int MID_FRAME_PIX = 100;
    localparam int MAX_RECORDS   = 64;

    logic      clk = 1'b0;
    logic      arst_n;
    cpu_addr_t cpu_addr;
    cpu_data_t cpu_dout;
    logic      cpu_we;
    logic      rom_req;
    rom_addr_t rom_addr;
    logic      rom_credit;
    logic      rom_valid;
    rom_data_t rom_data;
    logic      pix_valid;
    logic      pix_ready;
    chan_t     red;
    chan_t     green;
    chan_t     blue;
    logic      pix_last;

    // Reference state and ROM contents
    rom_data_t   rom_model [2048];
    map_entry_t  map_model [MAP_WORDS];
    logic [14:0] pal_model [PAL_WORDS];
    logic        flip_model;
    logic        en_model;
    logic [47:0] records [MAX_RECORDS];

    rom_addr_t   rom_addr_q [$];
    int          rom_due_q [$];
    rom_addr_t   head_addr;
    logic [14:0] exp_colour;
    logic [31:0] rnd_state;
    int          cycle_count;
    int          pix_count;
    int          req_count;
    logic        frame_active;
    logic        frame_done;
    logic        stall_mode;
    string       test_name;

    s16_char_game UUT (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .cpu_we     ( cpu_we     ),
        .rom_req    ( rom_req    ),
        .rom_addr   ( rom_addr   ),
        .rom_credit ( rom_credit ),
        .rom_valid  ( rom_valid  ),
        .rom_data   ( rom_data   ),
        .pix_valid  ( pix_valid  ),
        .pix_ready  ( pix_ready  ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .pix_last   ( pix_last   )
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_test(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_pixel(input string name, input chan_t exp_r, input chan_t exp_g,
                                 input chan_t exp_b, input chan_t act_r, input chan_t act_g,
                                 input chan_t act_b);
        if ({exp_r, exp_g, exp_b} !== {act_r, act_g, act_b}) begin
            $display("MISMATCH %s expected=%h/%h/%h actual=%h/%h/%h",
                     name, exp_r, exp_g, exp_b, act_r, act_g, act_b);
            fail_test("pixel colour differs from the reference frame");
        end
    endtask

    task automatic compare_rom_addr(input string name, input rom_addr_t exp, input rom_addr_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected=%h actual=%h", name, exp, act);
            fail_test("ROM request address out of raster order");
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("MISMATCH %s expected=%0d actual=%0d", name, exp, act);
            fail_test("wrong number of transfers in the frame");
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected=%b actual=%b", name, exp, act);
            fail_test("frame end flag in the wrong place");
        end
    endtask

    // Request n of a frame, walking columns per line
    function automatic rom_addr_t expected_rom_addr(input int n);
        int line;
        int col;
        map_entry_t entry;
        line  = n / MAP_COLS;
        col   = flip_model ? MAP_COLS - 1 - n % MAP_COLS : n % MAP_COLS;
        entry = map_model[3'((line / TILE_PX) * MAP_COLS + col)];
        return {entry[7:0], 3'(line % TILE_PX)};
    endfunction

    function automatic logic [14:0] expected_colour(input int n);
        int line;
        int sx;
        map_entry_t entry;
        rom_data_t word;
        logic [3:0] nib;
        line = n / FRAME_W;
        // Flip mirrors the whole line
        sx    = flip_model ? FRAME_W - 1 - n % FRAME_W : n % FRAME_W;
        entry = map_model[3'((line / TILE_PX) * MAP_COLS + sx / TILE_PX)];
        word  = rom_model[{entry[7:0], 3'(line % TILE_PX)}];
        nib   = 4'(word >> (4 * (TILE_PX - 1 - sx % TILE_PX)));
        if (!en_model) begin
            return '0;
        end
        return pal_model[{entry[10:8], nib}];
    endfunction

    function automatic string frame_name(input logic [11:0] flags, input cpu_data_t ctrl);
        if (flags[1]) return "ignored_go";
        if (flags[0]) return "back_pressure";
        if (!ctrl[CTRL_EN_BIT]) return "video_disable";
        if (ctrl[CTRL_FLIP_BIT]) return "hflip";
        return "render";
    endfunction

    task automatic cpu_write(input cpu_addr_t addr, input cpu_data_t data);
        int a;
        @(negedge clk);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = 1'b1;
        @(negedge clk);
        cpu_we = 1'b0;
        a = int'(addr);
        if (a >= int'(ADDR_MAP_BASE) && a < int'(ADDR_MAP_BASE) + MAP_WORDS) begin
            map_model[3'(a - int'(ADDR_MAP_BASE))] = data;
        end else if (a >= int'(ADDR_PAL_BASE) && a < int'(ADDR_PAL_BASE) + PAL_WORDS) begin
            pal_model[pal_idx_t'(a - int'(ADDR_PAL_BASE))] = data[14:0];
        end else if (addr == ADDR_CTRL) begin
            flip_model = data[CTRL_FLIP_BIT];
            en_model   = data[CTRL_EN_BIT];
        end
    endtask

    task automatic load_palette();
        for (int i = 0; i < PAL_WORDS; i++) begin
            cpu_write(ADDR_PAL_BASE + cpu_addr_t'(i), cpu_data_t'(i * 227 + 13));
        end
    endtask

    task automatic run_frame(input logic [11:0] flags, input cpu_data_t ctrl);
        int waited;
        @(posedge clk);
        test_name    = frame_name(flags, ctrl);
        pix_count    = 0;
        req_count    = 0;
        frame_done   = 1'b0;
        stall_mode   = flags[0];
        frame_active = 1'b1;
        cpu_write(ADDR_CTRL, ctrl);
        if (flags[1]) begin
            waited = 0;
            while (pix_count < MID_FRAME_PIX) begin
                @(posedge clk);
                waited++;
                if (waited > FRAME_TIMEOUT) fail_test("timeout waiting for mid frame");
            end
            // Second go while the walker is busy
            cpu_write(ADDR_CTRL, ctrl);
        end
        waited = 0;
        while (!frame_done) begin
            @(posedge clk);
            waited++;
            if (waited > FRAME_TIMEOUT) fail_test("timeout waiting for the last pixel");
        end
        frame_active = 1'b0;
        stall_mode   = 1'b0;
        // Nothing may follow the last pixel
        repeat (QUIET_CYCLES) @(posedge clk);
        compare_count({test_name, " pixels"}, FRAME_PIXELS, pix_count);
        compare_count({test_name, " requests"}, FRAME_REQS, req_count);
    endtask

    // Pixel sink and graphics ROM, sampled and driven between rising edges
    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (arst_n) begin
            if (frame_active && stall_mode) begin
                rnd_state = xorshift32(rnd_state);
                pix_ready = rnd_state[2:0] > 3'd2;
            end else begin
                pix_ready = 1'b1;
            end
            if (pix_valid && pix_ready) begin
                if (!frame_active) fail_test("pixel arrived with no frame running");
                if (pix_count >= FRAME_PIXELS) fail_test("frame ran past its last pixel");
                exp_colour = expected_colour(pix_count);
                compare_pixel($sformatf("%s pixel %0d", test_name, pix_count),
                              exp_colour[14:10], exp_colour[9:5], exp_colour[4:0],
                              red, green, blue);
                compare_flag($sformatf("%s last %0d", test_name, pix_count),
                             pix_count == FRAME_PIXELS - 1, pix_last);
                pix_count = pix_count + 1;
                if (pix_last) frame_done = 1'b1;
            end
            if (rom_req) begin
                if (!frame_active) fail_test("ROM request with no frame running");
                if (rom_addr_q.size() >= FETCH_CREDITS) fail_test("ROM request with no free slot");
                if (req_count >= FRAME_REQS) fail_test("more ROM requests than tile rows");
                compare_rom_addr($sformatf("%s request %0d", test_name, req_count),
                                 expected_rom_addr(req_count), rom_addr);
                req_count = req_count + 1;
            end
            if (rom_addr_q.size() > 0 && rom_due_q[0] <= cycle_count) begin
                head_addr  = rom_addr_q.pop_front();
                rom_due_q.delete(0);
                rom_data   = rom_model[head_addr];
                rom_valid  = 1'b1;
                rom_credit = 1'b1;
            end else begin
                rom_valid  = 1'b0;
                rom_credit = 1'b0;
            end
            if (rom_req) begin
                rnd_state = xorshift32(rnd_state);
                rom_addr_q.push_back(rom_addr);
                rom_due_q.push_back(cycle_count + 1 + int'(rnd_state % 32'd6));
            end
        end
    end

    initial begin
        int n;
        logic [47:0] rec;
        arst_n       = 1'b0;
        cpu_addr     = '0;
        cpu_dout     = '0;
        cpu_we       = 1'b0;
        rom_credit   = 1'b0;
        rom_valid    = 1'b0;
        rom_data     = '0;
        pix_ready    = 1'b1;
        rnd_state    = 32'h5fa;
        cycle_count  = 0;
        pix_count    = 0;
        req_count    = 0;
        frame_active = 1'b0;
        frame_done   = 1'b0;
        stall_mode   = 1'b0;
        flip_model   = 1'b0;
        en_model     = 1'b0;
        test_name    = "setup";
        for (int i = 0; i < 2048; i++) begin
            rom_model[i] = {rom_addr_t'(i), ~rom_addr_t'(i), 10'(i)};
        end
        for (int i = 0; i < MAP_WORDS; i++) begin
            map_model[i] = '0;
        end
        for (int i = 0; i < MAX_RECORDS; i++) begin
            records[i] = '0;
        end
        $readmemh("tb/s16_char_testdata.hex", records);
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        load_palette();
        n = 0;
        while (n < MAX_RECORDS && records[n][47:44] != 4'h0) begin
            rec = records[n];
            case (rec[47:44])
                4'h1: rom_model[rec[42:32]] = rec[31:0];
                4'h2: cpu_write(rec[40:32], rec[15:0]);
                4'h3: run_frame(rec[43:32], rec[15:0]);
                default: fail_test("unknown record tag in the data file");
            endcase
            n++;
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== tb/s16_char_testdata.hex ====
// Columns: tag (1 digit), field (3 digits), value (8 digits)
// Tag 1 ROM row at field, 2 CPU write at field, 3 frame (field bit 0 stalls, bit 1 second go)
// Tag 0 ends the records
// ROM rows for tiles 0x10 and 0x11, other rows use the address pattern
108001234567
108189abcdef
1082ffff0000
10830f0f0f0f
108876543210
10890000ffff
// Tile map, code in 7:0 and bank in 10:8
200000000010
200100000111
200200000225
200300000310
20040000043a
200500000511
20060000f6ff
200700000707
// Palette overrides
208500007fff
20ff00001234
// Writes that hit no register
200c0000beef
210100000001
// Frames: render, flip, video off, stalls, second go
300000000005
300000000007
300000000001
300100000005
300200000005
000000000000

// ==== files.f ====
hw/s16_char_pkg.sv
hw/s16_bus_decode.sv
hw/s16_char_fetch.sv
hw/s16_char_colmix.sv
hw/s16_char_game.sv
tb/s16_char_asserts.sv
tb/tb_s16_char_game.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS ?= --lint-only -Wall --timing --assert --timescale 1ns/1ns
TOP       ?= tb_s16_char_game
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
